/* verilog/hci_pkg.sv */
// PIO queue shared definitions
`default_nettype none

package hci_pkg;

  parameter int unsigned CsrDataWidth = 32;
  parameter int unsigned CsrAddrWidth = 12;
  parameter int unsigned ThldWidth = 8;
  parameter int unsigned CountFieldWidth = 8;

  typedef logic [CsrDataWidth-1:0] dword_t;
  typedef logic [CsrAddrWidth-1:0] csr_addr_t;
  typedef logic [ThldWidth-1:0] thld_t;

  // Second port write lands in hi, first in lo
  typedef struct packed {
    dword_t hi;
    dword_t lo;
  } cmd_desc_t;

  typedef logic [CsrDataWidth-1:0] resp_desc_t;

  // Register map
  parameter csr_addr_t CmdPortAddr = 12'h00C;
  parameter csr_addr_t RespPortAddr = 12'h010;
  parameter csr_addr_t QueueThldAddr = 12'h01C;
  parameter csr_addr_t ResetCtrlAddr = 12'h02C;
  parameter csr_addr_t QueueStatusAddr = 12'h030;

  // QUEUE_THLD fields
  parameter int unsigned CmdThldLsb = 0;
  parameter int unsigned RespThldLsb = 8;

  // RESET_CONTROL flush bits
  parameter int unsigned CmdFlushBit = 1;
  parameter int unsigned RespFlushBit = 2;

  // QUEUE_STATUS entry counts
  parameter int unsigned CmdCountLsb = 0;
  parameter int unsigned RespCountLsb = 8;

endpackage

`default_nettype wire

/* verilog/hci_queue_ctrl_if.sv */
// Queue control link
`timescale 1ns/1ps
`default_nettype none

interface hci_queue_ctrl_if #(
  parameter int unsigned Depth = 8
);
  import hci_pkg::*;

  localparam int unsigned CntWidth = $clog2(Depth + 1);

  thld_t ready_thld;
  logic flush_req; // Single cycle
  logic [CntWidth-1:0] count;
  logic full;
  logic empty;
  logic thld_trig;

  modport regs (
    output ready_thld,
    output flush_req,
    input  count,
    input  full,
    input  empty,
    input  thld_trig
  );

  modport queue (
    input  ready_thld,
    input  flush_req,
    output count,
    output full,
    output empty,
    output thld_trig
  );

endinterface

`default_nettype wire

/* verilog/hci_fifo.sv */
// Circular buffer FIFO
`timescale 1ns/1ps
`default_nettype none

module hci_fifo #(
  parameter type entry_t = logic,
  parameter int unsigned Depth = 8,
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int unsigned CntWidth = $clog2(Depth + 1)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic                push_i,
  input  entry_t              wdata_i,
  input  logic                pop_i,
  output entry_t              rdata_o,
  output logic [CntWidth-1:0] count_o,
  output logic                full_o,
  output logic                empty_o
);

  entry_t mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;
  logic push_ok, pop_ok;

  function automatic logic [PtrWidth-1:0] next_ptr(logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ok = push_i & ~full_o;
  assign pop_ok = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_ok) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push_ok && !pop_ok) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= wdata_i;
  end

  assign rdata_o = mem_q[rd_ptr_q];
  assign count_o = cnt_q;
  assign full_o = (cnt_q == CntWidth'(Depth));
  assign empty_o = (cnt_q == '0);

endmodule

`default_nettype wire

/* verilog/hci_cmd_queue.sv */
// Command queue
`timescale 1ns/1ps
`default_nettype none

module hci_cmd_queue #(
  parameter int unsigned Depth = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                port_req_i,
  input  hci_pkg::dword_t     port_wdata_i,
  output logic                port_ack_o,
  hci_queue_ctrl_if.queue     ctrl,
  output logic                cmd_rvalid_o,
  input  logic                cmd_rready_i,
  output hci_pkg::cmd_desc_t  cmd_rdata_o
);
  import hci_pkg::*;

  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic half_q; // First DWORD held
  logic pend_q; // Second DWORD waiting for space
  dword_t first_q;
  logic first_go, second_go;
  logic ack_q, trig_q;
  cmd_desc_t desc;
  thld_t eff_thld;
  logic [CntWidth-1:0] free_cnt;

  assign first_go = port_req_i & ~half_q;
  assign second_go = (port_req_i | pend_q) & half_q & ~ctrl.full;
  assign desc = '{hi: port_wdata_i, lo: first_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      half_q <= 1'b0;
      pend_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= first_go | second_go;
      if (ctrl.flush_req) begin
        half_q <= 1'b0;
      end else if (first_go) begin
        half_q <= 1'b1;
      end else if (second_go) begin
        half_q <= 1'b0;
      end
      if (second_go) begin
        pend_q <= 1'b0;
      end else if (port_req_i && half_q) begin
        pend_q <= 1'b1; // Back-pressure
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (first_go) first_q <= port_wdata_i;
  end

  hci_fifo #(
    .entry_t(cmd_desc_t),
    .Depth  (Depth)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .flush_i(ctrl.flush_req),
    .push_i (second_go),
    .wdata_i(desc),
    .pop_i  (cmd_rready_i & cmd_rvalid_o),
    .rdata_o(cmd_rdata_o),
    .count_o(ctrl.count),
    .full_o (ctrl.full),
    .empty_o(ctrl.empty)
  );

  // Free space trigger
  assign free_cnt = CntWidth'(Depth) - ctrl.count;
  assign eff_thld = (ctrl.ready_thld == '0) ? thld_t'(1) : ctrl.ready_thld;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) trig_q <= 1'b0;
    else trig_q <= (thld_t'(free_cnt) >= eff_thld);
  end

  assign ctrl.thld_trig = trig_q;
  assign cmd_rvalid_o = ~ctrl.empty;
  assign port_ack_o = ack_q;

endmodule

`default_nettype wire

/* verilog/hci_resp_queue.sv */
// Response queue
`timescale 1ns/1ps
`default_nettype none

module hci_resp_queue #(
  parameter int unsigned Depth = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                port_req_i,
  output logic                port_ack_o,
  output hci_pkg::dword_t     port_rdata_o,
  hci_queue_ctrl_if.queue     ctrl,
  input  logic                resp_wvalid_i,
  output logic                resp_wready_o,
  input  hci_pkg::resp_desc_t resp_wdata_i
);
  import hci_pkg::*;

  logic pend_q; // Read waiting for data
  logic read_go;
  logic ack_q, trig_q;
  dword_t rdata_q;
  resp_desc_t head;
  thld_t eff_thld;

  assign read_go = (port_req_i | pend_q) & ~ctrl.empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= read_go;
      if (read_go) begin
        pend_q <= 1'b0;
      end else if (port_req_i) begin
        pend_q <= 1'b1;
      end
    end
  end

  // Popped word stays put through the ack cycle
  always_ff @(posedge clk_i) begin
    if (read_go) rdata_q <= head;
  end

  hci_fifo #(
    .entry_t(resp_desc_t),
    .Depth  (Depth)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .flush_i(ctrl.flush_req),
    .push_i (resp_wvalid_i & resp_wready_o),
    .wdata_i(resp_wdata_i),
    .pop_i  (read_go),
    .rdata_o(head),
    .count_o(ctrl.count),
    .full_o (ctrl.full),
    .empty_o(ctrl.empty)
  );

  // Fill level trigger
  assign eff_thld = (ctrl.ready_thld == '0) ? thld_t'(1) : ctrl.ready_thld;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) trig_q <= 1'b0;
    else trig_q <= (thld_t'(ctrl.count) >= eff_thld);
  end

  assign ctrl.thld_trig = trig_q;
  assign resp_wready_o = ~ctrl.full;
  assign port_ack_o = ack_q;
  assign port_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* verilog/hci_csr_regs.sv */
// PIO queue register block
`timescale 1ns/1ps
`default_nettype none

module hci_csr_regs #(
  parameter int unsigned CmdDepth = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               csr_req_i,
  input  logic               csr_req_is_wr_i,
  input  hci_pkg::csr_addr_t csr_addr_i,
  input  hci_pkg::dword_t    csr_wr_data_i,
  output logic               csr_rd_ack_o,
  output hci_pkg::dword_t    csr_rd_data_o,
  output logic               csr_rd_err_o,
  output logic               csr_wr_ack_o,
  output logic               csr_wr_err_o,
  output logic               cmd_req_o,
  output hci_pkg::dword_t    cmd_wdata_o,
  input  logic               cmd_ack_i,
  output logic               resp_req_o,
  input  logic               resp_ack_i,
  input  hci_pkg::dword_t    resp_rdata_i,
  hci_queue_ctrl_if.regs     cmd_ctrl,
  hci_queue_ctrl_if.regs     resp_ctrl
);
  import hci_pkg::*;

  logic busy_q; // Host still holds the request
  logic start, wr, rd;
  logic is_cmd, is_resp, is_thld, is_rst, is_status;
  logic wr_ok, rd_ok;
  logic wr_ack_q, wr_err_q, rd_ack_q, rd_err_q;
  logic cmd_flush_q, resp_flush_q;
  thld_t cmd_thld_q, resp_thld_q;
  dword_t rd_word, rd_data_q;

  function automatic thld_t clip_thld(thld_t val, int unsigned depth);
    if (val > thld_t'(depth)) begin
      return thld_t'(depth);
    end
    return val;
  endfunction

  assign start = csr_req_i & ~busy_q;
  assign wr = start & csr_req_is_wr_i;
  assign rd = start & ~csr_req_is_wr_i;

  assign is_cmd = (csr_addr_i == CmdPortAddr);
  assign is_resp = (csr_addr_i == RespPortAddr);
  assign is_thld = (csr_addr_i == QueueThldAddr);
  assign is_rst = (csr_addr_i == ResetCtrlAddr);
  assign is_status = (csr_addr_i == QueueStatusAddr);

  assign wr_ok = is_cmd | is_thld | is_rst;
  assign rd_ok = is_resp | is_thld | is_rst | is_status;

  // Port accesses are acked by the queues
  assign cmd_req_o = wr & is_cmd;
  assign resp_req_o = rd & is_resp;
  assign cmd_wdata_o = csr_wr_data_i;

  always_comb begin
    rd_word = '0;
    if (is_thld) begin
      rd_word[CmdThldLsb +: ThldWidth] = cmd_thld_q;
      rd_word[RespThldLsb +: ThldWidth] = resp_thld_q;
    end else if (is_rst) begin
      rd_word[CmdFlushBit] = cmd_flush_q;
      rd_word[RespFlushBit] = resp_flush_q;
    end else if (is_status) begin
      rd_word[CmdCountLsb +: CountFieldWidth] = CountFieldWidth'(cmd_ctrl.count);
      rd_word[RespCountLsb +: CountFieldWidth] = CountFieldWidth'(resp_ctrl.count);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      wr_ack_q <= 1'b0;
      wr_err_q <= 1'b0;
      rd_ack_q <= 1'b0;
      rd_err_q <= 1'b0;
      cmd_thld_q <= thld_t'(1);
      resp_thld_q <= thld_t'(1);
      cmd_flush_q <= 1'b0;
      resp_flush_q <= 1'b0;
    end else begin
      busy_q <= csr_req_i;
      wr_ack_q <= wr & ~is_cmd;
      wr_err_q <= wr & ~wr_ok;
      rd_ack_q <= rd & ~is_resp;
      rd_err_q <= rd & ~rd_ok;
      if (wr && is_thld) begin
        cmd_thld_q <= clip_thld(csr_wr_data_i[CmdThldLsb +: ThldWidth], CmdDepth);
        resp_thld_q <= clip_thld(csr_wr_data_i[RespThldLsb +: ThldWidth], RespDepth);
      end
      // Flush bits clear themselves together with the queue
      cmd_flush_q <= wr & is_rst & csr_wr_data_i[CmdFlushBit];
      resp_flush_q <= wr & is_rst & csr_wr_data_i[RespFlushBit];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd) rd_data_q <= rd_word;
  end

  assign cmd_ctrl.ready_thld = cmd_thld_q;
  assign cmd_ctrl.flush_req = cmd_flush_q;
  assign resp_ctrl.ready_thld = resp_thld_q;
  assign resp_ctrl.flush_req = resp_flush_q;

  assign csr_wr_ack_o = wr_ack_q | cmd_ack_i;
  assign csr_wr_err_o = wr_err_q;
  assign csr_rd_ack_o = rd_ack_q | resp_ack_i;
  assign csr_rd_err_o = rd_err_q;
  assign csr_rd_data_o = resp_ack_i ? resp_rdata_i : rd_data_q;

endmodule

`default_nettype wire

/* verilog/hci_top.sv */
// HCI PIO queue block
`timescale 1ns/1ps
`default_nettype none

module hci_top #(
  parameter int unsigned CmdDepth = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // CSR bus
  input  logic                csr_req_i,
  input  logic                csr_req_is_wr_i,
  input  hci_pkg::csr_addr_t  csr_addr_i,
  input  hci_pkg::dword_t     csr_wr_data_i,
  output logic                csr_rd_ack_o,
  output hci_pkg::dword_t     csr_rd_data_o,
  output logic                csr_rd_err_o,
  output logic                csr_wr_ack_o,
  output logic                csr_wr_err_o,
  // Controller side
  output logic                cmd_rvalid_o,
  input  logic                cmd_rready_i,
  output hci_pkg::cmd_desc_t  cmd_rdata_o,
  input  logic                resp_wvalid_i,
  output logic                resp_wready_o,
  input  hci_pkg::resp_desc_t resp_wdata_i,
  // Queue status
  output logic                cmd_full_o,
  output logic                cmd_empty_o,
  output logic                cmd_thld_trig_o,
  output logic                resp_full_o,
  output logic                resp_empty_o,
  output logic                resp_thld_trig_o
);
  import hci_pkg::*;

  logic cmd_req, cmd_ack;
  logic resp_req, resp_ack;
  dword_t cmd_wdata, resp_rdata;

  hci_queue_ctrl_if #(.Depth(CmdDepth)) cmd_ctrl ();
  hci_queue_ctrl_if #(.Depth(RespDepth)) resp_ctrl ();

  hci_csr_regs #(
    .CmdDepth (CmdDepth),
    .RespDepth(RespDepth)
  ) u_regs (
    .clk_i, .rst_ni,
    .csr_req_i, .csr_req_is_wr_i, .csr_addr_i, .csr_wr_data_i,
    .csr_rd_ack_o, .csr_rd_data_o, .csr_rd_err_o, .csr_wr_ack_o, .csr_wr_err_o,
    .cmd_req_o   (cmd_req),
    .cmd_wdata_o (cmd_wdata),
    .cmd_ack_i   (cmd_ack),
    .resp_req_o  (resp_req),
    .resp_ack_i  (resp_ack),
    .resp_rdata_i(resp_rdata),
    .cmd_ctrl    (cmd_ctrl.regs),
    .resp_ctrl   (resp_ctrl.regs)
  );

  hci_cmd_queue #(.Depth(CmdDepth)) u_cmd_queue (
    .clk_i, .rst_ni,
    .port_req_i  (cmd_req),
    .port_wdata_i(cmd_wdata),
    .port_ack_o  (cmd_ack),
    .ctrl        (cmd_ctrl.queue),
    .cmd_rvalid_o, .cmd_rready_i, .cmd_rdata_o
  );

  hci_resp_queue #(.Depth(RespDepth)) u_resp_queue (
    .clk_i, .rst_ni,
    .port_req_i  (resp_req),
    .port_ack_o  (resp_ack),
    .port_rdata_o(resp_rdata),
    .ctrl        (resp_ctrl.queue),
    .resp_wvalid_i, .resp_wready_o, .resp_wdata_i
  );

  assign cmd_full_o = cmd_ctrl.full;
  assign cmd_empty_o = cmd_ctrl.empty;
  assign cmd_thld_trig_o = cmd_ctrl.thld_trig;
  assign resp_full_o = resp_ctrl.full;
  assign resp_empty_o = resp_ctrl.empty;
  assign resp_thld_trig_o = resp_ctrl.thld_trig;

endmodule

`default_nettype wire

/* testbench/hci_tb_tasks.svh */
// PIO queue bus tasks and directed tests
`ifndef HCI_TB_TASKS_SVH
`define HCI_TB_TASKS_SVH
`default_nettype none

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic csr_start(input logic is_wr, input csr_addr_t addr, input dword_t data);
    @(posedge clk_i);
    csr_req_i <= 1'b1;
    csr_req_is_wr_i <= is_wr;
    csr_addr_i <= addr;
    csr_wr_data_i <= data;
  endtask

  // Returns on the first ack or after max_cycles
  task automatic csr_wait_ack(input int max_cycles, output logic got, output dword_t data,
                              output logic err);
    int n;
    n = 0;
    got = 1'b0;
    data = '0;
    err = 1'b0;
    while (!got && n < max_cycles) begin
      @(negedge clk_i);
      n++;
      if (csr_wr_ack_o || csr_rd_ack_o) begin
        got = 1'b1;
        data = csr_rd_data_o;
        err = csr_wr_ack_o ? csr_wr_err_o : csr_rd_err_o;
      end
    end
  endtask

  task automatic csr_release();
    @(posedge clk_i);
    csr_req_i <= 1'b0;
  endtask

  task automatic csr_access(input logic is_wr, input csr_addr_t addr, input dword_t wdata,
                            output dword_t rdata, output logic err);
    logic got;
    csr_start(is_wr, addr, wdata);
    csr_wait_ack(AckTimeout, got, rdata, err);
    if (!got) abort_run($sformatf("CSR access to 0x%0h was never acknowledged", addr));
    csr_release();
  endtask

  task automatic csr_write_ok(input csr_addr_t addr, input dword_t data);
    dword_t rdata;
    logic err;
    csr_access(1'b1, addr, data, rdata, err);
    check_value("csr_wr_err_o", err, 1'b0);
  endtask

  task automatic csr_read_check(input csr_addr_t addr, input dword_t expected);
    dword_t rdata;
    logic err;
    csr_access(1'b0, addr, '0, rdata, err);
    check_value("csr_rd_err_o", err, 1'b0);
    check_value("csr_rd_data_o", rdata, expected);
  endtask

  task automatic write_cmd(input dword_t lo, input dword_t hi);
    csr_write_ok(CmdPortAddr, lo);
    csr_write_ok(CmdPortAddr, hi);
    cmd_level++;
  endtask

  task automatic pop_cmd_check(input cmd_desc_t expected);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!cmd_rvalid_o && n < AckTimeout);
    if (!cmd_rvalid_o) abort_run("Command queue never offered a descriptor");
    check_value("cmd_rdata_o", cmd_rdata_o, expected);
    @(posedge clk_i);
    cmd_rready_i <= 1'b1;
    @(posedge clk_i);
    cmd_rready_i <= 1'b0; // One pop
    cmd_level--;
  endtask

  task automatic push_resp(input resp_desc_t data);
    int n;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while (!resp_wready_o && n < AckTimeout);
    if (!resp_wready_o) abort_run("Response queue never became ready");
    @(posedge clk_i);
    resp_wvalid_i <= 1'b1;
    resp_wdata_i <= data;
    @(posedge clk_i);
    resp_wvalid_i <= 1'b0;
    resp_level++;
  endtask

  task automatic read_resp_check(input resp_desc_t expected);
    csr_read_check(RespPortAddr, expected);
    resp_level--;
  endtask

  // Triggers follow the level a cycle late
  task automatic check_triggers(input int cmd_thld, input int resp_thld);
    logic exp_cmd;
    logic exp_resp;
    int n;
    exp_cmd = (int'(CmdDepth) - cmd_level) >= ((cmd_thld == 0) ? 1 : cmd_thld);
    exp_resp = resp_level >= ((resp_thld == 0) ? 1 : resp_thld);
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while ((cmd_thld_trig_o !== exp_cmd || resp_thld_trig_o !== exp_resp) && n < 4);
    check_value("cmd_thld_trig_o", cmd_thld_trig_o, exp_cmd);
    check_value("resp_thld_trig_o", resp_thld_trig_o, exp_resp);
  endtask

  task automatic check_reset_outputs();
    check_value("csr_rd_ack_o", csr_rd_ack_o, 1'b0);
    check_value("csr_wr_ack_o", csr_wr_ack_o, 1'b0);
    check_value("csr_rd_err_o", csr_rd_err_o, 1'b0);
    check_value("csr_wr_err_o", csr_wr_err_o, 1'b0);
    check_value("cmd_rvalid_o", cmd_rvalid_o, 1'b0);
    check_value("cmd_thld_trig_o", cmd_thld_trig_o, 1'b0);
    check_value("resp_thld_trig_o", resp_thld_trig_o, 1'b0);
    check_value("resp_wready_o", resp_wready_o, 1'b1);
    check_value("cmd_empty_o", cmd_empty_o, 1'b1);
    check_value("resp_empty_o", resp_empty_o, 1'b1);
  endtask

  task automatic test_reset_values();
    dword_t rdata;
    logic err;
    csr_read_check(QueueThldAddr, 32'h0000_0101);
    csr_read_check(QueueStatusAddr, 32'h0);
    csr_read_check(ResetCtrlAddr, 32'h0);
    @(negedge clk_i);
    check_value("cmd_rvalid_o", cmd_rvalid_o, 1'b0);
    check_value("resp_empty_o", resp_empty_o, 1'b1);
    csr_access(1'b0, 12'h100, '0, rdata, err); // Unmapped
    check_value("csr_rd_err_o", err, 1'b1);
    check_value("csr_rd_data_o", rdata, 32'h0);
  endtask

  task automatic test_cmd_path();
    cmd_desc_t sent[$];
    cmd_desc_t d;
    repeat (5) begin
      d.lo = $random(seed);
      d.hi = $random(seed);
      write_cmd(d.lo, d.hi);
      sent.push_back(d);
    end
    csr_read_check(QueueStatusAddr, 32'd5);
    while (sent.size() > 0) pop_cmd_check(sent.pop_front());
  endtask

  task automatic test_cmd_backpressure();
    cmd_desc_t sent[$];
    cmd_desc_t d;
    dword_t rdata;
    logic got;
    logic err;
    repeat (CmdDepth) begin
      d.lo = $random(seed);
      d.hi = $random(seed);
      write_cmd(d.lo, d.hi);
      sent.push_back(d);
    end
    @(negedge clk_i);
    check_value("cmd_full_o", cmd_full_o, 1'b1);
    d.lo = $random(seed);
    d.hi = $random(seed);
    csr_write_ok(CmdPortAddr, d.lo);
    csr_start(1'b1, CmdPortAddr, d.hi);
    csr_wait_ack(20, got, rdata, err);
    if (got) abort_run("Second command half was acknowledged while the queue was full");
    pop_cmd_check(sent.pop_front());
    csr_wait_ack(AckTimeout, got, rdata, err);
    if (!got) abort_run("Second command half was not acknowledged after a pop");
    csr_release();
    cmd_level++;
    sent.push_back(d);
    while (sent.size() > 0) pop_cmd_check(sent.pop_front());
  endtask

  task automatic test_resp_path();
    resp_desc_t sent[$];
    resp_desc_t w;
    dword_t rdata;
    logic got;
    logic err;
    repeat (4) begin
      w = $random(seed);
      push_resp(w);
      sent.push_back(w);
    end
    while (sent.size() > 0) read_resp_check(sent.pop_front());
    csr_start(1'b0, RespPortAddr, '0);
    csr_wait_ack(20, got, rdata, err);
    if (got) abort_run("Read of the empty response queue was acknowledged");
    w = $random(seed);
    push_resp(w);
    csr_wait_ack(AckTimeout, got, rdata, err);
    if (!got) abort_run("Pending response read was not acknowledged after a push");
    csr_release();
    resp_level--;
    check_value("csr_rd_data_o", rdata, w);
    check_value("csr_rd_err_o", err, 1'b0);
    @(negedge clk_i);
    check_value("resp_empty_o", resp_empty_o, 1'b1);
  endtask

  task automatic test_thresholds();
    cmd_desc_t cmds[$];
    resp_desc_t resps[$];
    cmd_desc_t d;
    resp_desc_t w;
    csr_write_ok(QueueThldAddr, 32'h0000_3014); // Both above depth
    csr_read_check(QueueThldAddr, {16'h0, 8'(RespDepth), 8'(CmdDepth)});
    check_triggers(CmdDepth, RespDepth);
    csr_write_ok(QueueThldAddr, 32'h0);
    csr_read_check(QueueThldAddr, 32'h0);
    check_triggers(0, 0);
    csr_write_ok(QueueThldAddr, 32'h0000_0203);
    csr_read_check(QueueThldAddr, 32'h0000_0203);
    repeat (CmdDepth) begin
      check_triggers(3, 2);
      d.lo = $random(seed);
      d.hi = $random(seed);
      w = $random(seed);
      write_cmd(d.lo, d.hi);
      push_resp(w);
      cmds.push_back(d);
      resps.push_back(w);
    end
    while (cmds.size() > 0) begin
      check_triggers(3, 2);
      pop_cmd_check(cmds.pop_front());
      read_resp_check(resps.pop_front());
    end
    check_triggers(3, 2);
  endtask

  task automatic test_flush();
    dword_t rdata;
    logic err;
    int n;
    repeat (3) write_cmd($random(seed), $random(seed));
    repeat (RespDepth) push_resp($random(seed));
    csr_read_check(QueueStatusAddr, {16'h0, 8'(resp_level), 8'(cmd_level)});
    @(negedge clk_i);
    check_value("resp_full_o", resp_full_o, 1'b1);
    check_value("resp_wready_o", resp_wready_o, 1'b0);
    csr_write_ok(ResetCtrlAddr, dword_t'((1 << CmdFlushBit) | (1 << RespFlushBit)));
    n = 0;
    do begin
      csr_access(1'b0, ResetCtrlAddr, '0, rdata, err);
      n++;
    end while (rdata != '0 && n < 10);
    check_value("csr_rd_data_o", rdata, 32'h0);
    cmd_level = 0;
    resp_level = 0;
    csr_read_check(QueueStatusAddr, 32'h0);
    @(negedge clk_i);
    check_value("cmd_empty_o", cmd_empty_o, 1'b1);
    check_value("resp_empty_o", resp_empty_o, 1'b1);
    check_value("resp_full_o", resp_full_o, 1'b0);
    check_value("resp_wready_o", resp_wready_o, 1'b1);
  endtask

`default_nettype wire
`endif

/* testbench/tb_hci_top.sv */
// PIO queue block testbench
`timescale 1ns/1ps
`default_nettype none

module tb_hci_top;
  import hci_pkg::*;

  localparam int unsigned CmdDepth = 8;
  localparam int unsigned RespDepth = 8;
  localparam int AckTimeout = 50; // Cycles

  logic clk_i;
  logic rst_ni;
  logic csr_req_i;
  logic csr_req_is_wr_i;
  csr_addr_t csr_addr_i;
  dword_t csr_wr_data_i;
  logic csr_rd_ack_o;
  dword_t csr_rd_data_o;
  logic csr_rd_err_o;
  logic csr_wr_ack_o;
  logic csr_wr_err_o;
  logic cmd_rvalid_o;
  logic cmd_rready_i;
  cmd_desc_t cmd_rdata_o;
  logic resp_wvalid_i;
  logic resp_wready_o;
  resp_desc_t resp_wdata_i;
  logic cmd_full_o;
  logic cmd_empty_o;
  logic cmd_thld_trig_o;
  logic resp_full_o;
  logic resp_empty_o;
  logic resp_thld_trig_o;

  int errors;
  int seed;
  int cmd_level; // Entries the queues should hold
  int resp_level;

  hci_top #(
    .CmdDepth (CmdDepth),
    .RespDepth(RespDepth)
  ) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    errors++;
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "hci_tb_tasks.svh"

  initial begin
    errors = 0;
    seed = 91338;
    cmd_level = 0;
    resp_level = 0;
    rst_ni = 1'b0;
    csr_req_i = 1'b0;
    csr_req_is_wr_i = 1'b0;
    csr_addr_i = '0;
    csr_wr_data_i = '0;
    cmd_rready_i = 1'b0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i = '0;

    @(negedge clk_i);
    check_reset_outputs();
    @(posedge clk_i);
    rst_ni <= 1'b1; // Two rising edges under reset

    test_reset_values();
    test_cmd_path();
    test_cmd_backpressure();
    test_resp_path();
    test_thresholds();
    test_flush();

    if (errors == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1, "errors found");
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+testbench
verilog/hci_pkg.sv
verilog/hci_queue_ctrl_if.sv
verilog/hci_fifo.sv
verilog/hci_cmd_queue.sv
verilog/hci_resp_queue.sv
verilog/hci_csr_regs.sv
verilog/hci_top.sv
testbench/tb_hci_top.sv

/* run.sh */
#!/bin/sh
# Build and run the PIO queue testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 -f sim.f --top-module tb_hci_top -o tb_hci_top

# The log decides the result
./obj_dir/tb_hci_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
